// File: rtl/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

  // array geometry, rows carry pixels and columns carry weights
  localparam int ROWS = 4;
  localparam int COLS = 4;

  // operand and result widths
  localparam int X_BITS = 8;
  localparam int K_BITS = 8;
  localparam int Y_BITS = 24;

  // memory geometry, one word holds ROWS pixels or COLS weights
  localparam int ADDR_BITS = 8;
  localparam int WORD_BITS = 32;
  localparam int COUNT_BITS = 8;

  typedef logic signed [X_BITS-1:0] pixel_t;
  typedef logic signed [K_BITS-1:0] weight_t;
  typedef logic signed [Y_BITS-1:0] acc_t;
  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [COUNT_BITS-1:0] count_t;

  // run control states of the sequencer
  typedef enum logic [1:0] {IDLE, FETCH, ISSUE, WAIT_DRAIN} seq_state_t;

endpackage

`default_nettype wire

// File: rtl/operand_mem.sv
`timescale 1ns/1ps
`default_nettype none

module operand_mem import cnn_pkg::*; (
  input  logic  clk,
  input  logic  we,
  input  addr_t waddr,
  input  word_t wdata,
  input  logic  re,
  input  addr_t raddr,
  output word_t rdata
);

  // pixel words from address 0, weight words from the weight base
  word_t mem [2**ADDR_BITS];

  // one access per cycle on the single port
  // a write wins over a read in the same cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end else if (re) begin
      // read data shows up one cycle after re
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import cnn_pkg::*; (
  input  logic  clk,
  input  logic  resetn,
  // peer a is the pixel fetcher
  input  logic  req_a,
  input  addr_t addr_a,
  output logic  ack_a,
  // peer b is the weight fetcher
  input  logic  req_b,
  input  addr_t addr_b,
  output logic  ack_b,
  // read data shared by both peers and valid while an ack is high
  output word_t rdata,
  // host load path
  input  logic  load_we,
  input  addr_t load_addr,
  input  word_t load_data,
  // memory side
  output logic  mem_we,
  output addr_t mem_waddr,
  output word_t mem_wdata,
  output logic  mem_re,
  output addr_t mem_raddr,
  input  word_t mem_rdata
);

  typedef enum logic [1:0] {ARB_IDLE, ARB_READ, ARB_DATA, ARB_ACK} arb_state_t;

  arb_state_t state;
  // grant_b selects peer b for the current handshake
  logic grant_b;
  // last_b remembers who was served last for round-robin
  logic last_b;
  logic pick_b;
  logic granted_req;

  // on a tie the peer not served last wins
  assign pick_b = req_b && (!req_a || !last_b);
  assign granted_req = grant_b ? req_b : req_a;

  // host writes go straight to the memory
  assign mem_we = load_we;
  assign mem_waddr = load_addr;
  assign mem_wdata = load_data;

  // read slot is held off while the host writes
  assign mem_re = (state == ARB_READ) && !load_we;
  assign mem_raddr = grant_b ? addr_b : addr_a;

  assign ack_a = (state == ARB_ACK) && !grant_b;
  assign ack_b = (state == ARB_ACK) && grant_b;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= ARB_IDLE;
      grant_b <= 1'b0;
      last_b <= 1'b1;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (req_a || req_b) begin
            grant_b <= pick_b;
            last_b <= pick_b;
            state <= ARB_READ;
          end
        end
        ARB_READ: begin
          if (!load_we) begin
            state <= ARB_DATA;
          end
        end
        // memory output is valid in this state
        ARB_DATA: state <= ARB_ACK;
        // hold ack until the granted peer drops its req
        ARB_ACK: begin
          if (!granted_req) begin
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ARB_DATA) begin
      rdata <= mem_rdata;
    end
  end

  // the granted peer keeps its req up until its read is acked
  a_req_held: assert property (@(posedge clk) disable iff (!resetn)
    (state == ARB_READ || state == ARB_DATA) |-> granted_req);
  // an ack only rises on a live request from that peer
  a_ack_a_req: assert property (@(posedge clk) disable iff (!resetn) $rose(ack_a) |-> req_a);
  a_ack_b_req: assert property (@(posedge clk) disable iff (!resetn) $rose(ack_b) |-> req_b);

endmodule

`default_nettype wire

// File: rtl/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch import cnn_pkg::*; #(
  parameter addr_t BASE = '0
) (
  input  logic  clk,
  input  logic  resetn,
  input  logic  restart,
  // word handshake with the sequencer
  input  logic  word_req,
  output logic  word_ack,
  output word_t word,
  // memory handshake with the arbiter
  output logic  mem_req,
  output addr_t mem_addr,
  input  logic  mem_ack,
  input  word_t mem_rdata
);

  typedef enum logic [1:0] {F_IDLE, F_MEM, F_DONE} fetch_state_t;

  fetch_state_t state;
  // next word to read in this region
  addr_t addr_q;

  // address stays put for the whole memory handshake
  assign mem_addr = addr_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= F_IDLE;
      addr_q <= BASE;
      mem_req <= 1'b0;
      word_ack <= 1'b0;
    end else begin
      case (state)
        // new memory req only once the previous ack is gone
        F_IDLE: begin
          if (word_req && !mem_ack) begin
            mem_req <= 1'b1;
            state <= F_MEM;
          end
        end
        F_MEM: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            word_ack <= 1'b1;
            addr_q <= addr_q + addr_t'(1);
            state <= F_DONE;
          end
        end
        // wait for the sequencer to release its request
        F_DONE: begin
          if (!word_req) begin
            word_ack <= 1'b0;
            state <= F_IDLE;
          end
        end
        default: state <= F_IDLE;
      endcase
      // rewind to the region start at run start
      if (restart) begin
        addr_q <= BASE;
      end
    end
  end

  // capture the word on the memory ack
  always_ff @(posedge clk) begin
    if (state == F_MEM && mem_ack) begin
      word <= mem_rdata;
    end
  end

endmodule

`default_nettype wire

// File: rtl/conv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer import cnn_pkg::*; (
  input  logic    clk,
  input  logic    resetn,
  input  logic    start,
  input  count_t  depth,
  input  count_t  groups,
  output logic    busy,
  output logic    fetch_restart,
  // word handshakes with both fetchers
  output logic    pix_req,
  input  logic    pix_ack,
  input  word_t   pix_word,
  output logic    wgt_req,
  input  logic    wgt_ack,
  input  word_t   wgt_word,
  // beat stream into the engine
  output logic    s_valid,
  input  logic    s_ready,
  output pixel_t  [ROWS-1:0] s_pixels,
  output weight_t [COLS-1:0] s_weights,
  output logic    s_last,
  // m_last transfer seen on the output stream
  input  logic    out_last_done
);

  seq_state_t state;
  count_t depth_q;
  count_t groups_q;
  count_t beat_cnt;
  count_t group_cnt;
  // finished groups that have fully left the engine
  count_t done_cnt;
  logic beat_last;
  logic group_last;

  assign fetch_restart = (state == IDLE) && start;
  assign beat_last = (beat_cnt == depth_q - count_t'(1));
  assign group_last = (group_cnt == groups_q - count_t'(1));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= IDLE;
      busy <= 1'b0;
      pix_req <= 1'b0;
      wgt_req <= 1'b0;
      s_valid <= 1'b0;
      s_last <= 1'b0;
      beat_cnt <= '0;
      group_cnt <= '0;
      done_cnt <= '0;
    end else begin
      if (busy && out_last_done) begin
        done_cnt <= done_cnt + count_t'(1);
      end
      case (state)
        IDLE: begin
          if (start) begin
            depth_q <= depth;
            groups_q <= groups;
            busy <= 1'b1;
            beat_cnt <= '0;
            group_cnt <= '0;
            done_cnt <= '0;
            pix_req <= 1'b1;
            wgt_req <= 1'b1;
            state <= FETCH;
          end
        end
        // both fetches run in parallel
        FETCH: begin
          if (pix_req && pix_ack) begin
            pix_req <= 1'b0;
          end
          if (wgt_req && wgt_ack) begin
            wgt_req <= 1'b0;
          end
          // beat goes out once both handshakes have closed
          if (!pix_req && !wgt_req && !pix_ack && !wgt_ack) begin
            s_valid <= 1'b1;
            s_last <= beat_last;
            state <= ISSUE;
          end
        end
        ISSUE: begin
          if (s_ready) begin
            s_valid <= 1'b0;
            beat_cnt <= beat_last ? count_t'(0) : beat_cnt + count_t'(1);
            if (beat_last) begin
              group_cnt <= group_cnt + count_t'(1);
            end
            if (beat_last && group_last) begin
              state <= WAIT_DRAIN;
            end else begin
              pix_req <= 1'b1;
              wgt_req <= 1'b1;
              state <= FETCH;
            end
          end
        end
        // last group still in the array or shifter
        WAIT_DRAIN: begin
          if (out_last_done && done_cnt == groups_q - count_t'(1)) begin
            busy <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // beat payload, stable while s_valid is high
  always_ff @(posedge clk) begin
    if (state == FETCH && pix_req && pix_ack) begin
      s_pixels <= pix_word;
    end
    if (state == FETCH && wgt_req && wgt_ack) begin
      s_weights <= wgt_word;
    end
  end

endmodule

`default_nettype wire

// File: rtl/proc_engine.sv
`timescale 1ns/1ps
`default_nettype none

module proc_engine import cnn_pkg::*; (
  input  logic    clk,
  input  logic    resetn,
  // beat stream in
  input  logic    s_valid,
  input  logic    s_last,
  output logic    s_ready,
  input  pixel_t  [ROWS-1:0] s_pixels,
  input  weight_t [COLS-1:0] s_weights,
  // column stream out
  input  logic    m_ready,
  output logic    m_valid,
  output logic    m_last,
  output acc_t    [ROWS-1:0] m_data
);

  localparam int SHIFT_CNT_BITS = $clog2(COLS + 1);

  typedef logic signed [X_BITS+K_BITS-1:0] prod_t;

  // single enable for the whole array
  logic en;
  logic accept;
  // control pipeline alongside the data
  logic in_valid;
  logic in_last;
  logic mul_valid;
  logic mul_last;
  // acc holds a finished group
  logic acc_valid;
  // next accumulation starts from zero
  logic bypass_q;

  // pix_q[c] holds the pixel word from c beats back
  pixel_t [COLS-1:0][ROWS-1:0] pix_q;
  weight_t [COLS-1:0] wgt_q;
  prod_t [COLS-1:0][ROWS-1:0] mul_q;
  acc_t [COLS-1:0][ROWS-1:0] acc_q;
  acc_t [COLS-1:0][ROWS-1:0] shift_q;

  // columns left in the output shifter
  logic [SHIFT_CNT_BITS-1:0] shift_cnt;
  logic shift_empty;
  logic load;
  logic out_fire;

  assign shift_empty = (shift_cnt == '0);
  // freeze while a finished group waits on a busy shifter
  assign en = !(acc_valid && !shift_empty);
  assign s_ready = en;
  assign accept = s_valid && en;
  assign load = en && acc_valid;
  assign out_fire = m_valid && m_ready;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      in_valid <= 1'b0;
      in_last <= 1'b0;
      mul_valid <= 1'b0;
      mul_last <= 1'b0;
      acc_valid <= 1'b0;
      bypass_q <= 1'b1;
    end else if (en) begin
      in_valid <= s_valid;
      in_last <= s_valid && s_last;
      mul_valid <= in_valid;
      mul_last <= in_last;
      acc_valid <= mul_valid && mul_last;
      // restart accumulation after each group end
      if (mul_valid) begin
        bypass_q <= mul_last;
      end
    end
  end

  // pixel skew chain, one column per accepted beat
  // starts from zeros so early columns see empty history
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pix_q <= '0;
    end else if (accept) begin
      pix_q[0] <= s_pixels;
      for (int c = 1; c < COLS; c++) begin
        pix_q[c] <= pix_q[c-1];
      end
    end
  end

  // stage 1 weights, stage 2 products, stage 3 accumulate
  always_ff @(posedge clk) begin
    if (accept) begin
      wgt_q <= s_weights;
    end
    if (en && in_valid) begin
      for (int c = 0; c < COLS; c++) begin
        for (int r = 0; r < ROWS; r++) begin
          mul_q[c][r] <= pix_q[c][r] * wgt_q[c];
        end
      end
    end
    if (en && mul_valid) begin
      for (int c = 0; c < COLS; c++) begin
        for (int r = 0; r < ROWS; r++) begin
          acc_q[c][r] <= (bypass_q ? acc_t'(0) : acc_q[c][r]) + acc_t'(mul_q[c][r]);
        end
      end
    end
  end

  // output shifter count, loaded only when empty
  always_ff @(posedge clk) begin
    if (!resetn) begin
      shift_cnt <= '0;
    end else if (load) begin
      shift_cnt <= SHIFT_CNT_BITS'(COLS);
    end else if (out_fire) begin
      shift_cnt <= shift_cnt - 1'b1;
    end
  end

  // top column leaves first, column 0 ends the group
  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= acc_q;
    end else if (out_fire) begin
      for (int c = COLS - 1; c > 0; c--) begin
        shift_q[c] <= shift_q[c-1];
      end
    end
  end

  assign m_valid = !shift_empty;
  assign m_last = (shift_cnt == SHIFT_CNT_BITS'(1));
  assign m_data = shift_q[COLS-1];

  a_out_stable: assert property (@(posedge clk) disable iff (!resetn)
    m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

`default_nettype wire

// File: rtl/cnn_engine.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_engine import cnn_pkg::*; #(
  parameter addr_t WGT_BASE = 8'd128
) (
  input  logic   clk,
  input  logic   resetn,
  // host load, only while busy is low
  input  logic   load_we,
  input  addr_t  load_addr,
  input  word_t  load_data,
  // run control
  input  logic   start,
  input  count_t depth,
  input  count_t groups,
  output logic   busy,
  // column results
  output logic   out_valid,
  input  logic   out_ready,
  output acc_t   [ROWS-1:0] out_data,
  output logic   out_last
);

  logic mem_we;
  addr_t mem_waddr;
  word_t mem_wdata;
  logic mem_re;
  addr_t mem_raddr;
  word_t mem_rdata;
  word_t arb_rdata;

  logic pix_mem_req;
  logic pix_mem_ack;
  addr_t pix_mem_addr;
  logic wgt_mem_req;
  logic wgt_mem_ack;
  addr_t wgt_mem_addr;

  logic fetch_restart;
  logic pix_req;
  logic pix_ack;
  word_t pix_word;
  logic wgt_req;
  logic wgt_ack;
  word_t wgt_word;

  logic s_valid;
  logic s_ready;
  logic s_last;
  pixel_t [ROWS-1:0] s_pixels;
  weight_t [COLS-1:0] s_weights;

  logic out_last_done;
  // engine also clears at run start so the skew chain begins empty
  logic engine_resetn;

  assign out_last_done = out_valid && out_ready && out_last;
  assign engine_resetn = resetn && !fetch_restart;

  operand_mem i_operand_mem (
    .clk   (clk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .re    (mem_re),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

  // pixel fetcher on port a, weight fetcher on port b
  mem_arbiter i_mem_arbiter (
    .clk       (clk),
    .resetn    (resetn),
    .req_a     (pix_mem_req),
    .addr_a    (pix_mem_addr),
    .ack_a     (pix_mem_ack),
    .req_b     (wgt_mem_req),
    .addr_b    (wgt_mem_addr),
    .ack_b     (wgt_mem_ack),
    .rdata     (arb_rdata),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (load_data),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata),
    .mem_re    (mem_re),
    .mem_raddr (mem_raddr),
    .mem_rdata (mem_rdata)
  );

  operand_fetch #(.BASE(addr_t'(0))) i_pix_fetch (
    .clk       (clk),
    .resetn    (resetn),
    .restart   (fetch_restart),
    .word_req  (pix_req),
    .word_ack  (pix_ack),
    .word      (pix_word),
    .mem_req   (pix_mem_req),
    .mem_addr  (pix_mem_addr),
    .mem_ack   (pix_mem_ack),
    .mem_rdata (arb_rdata)
  );

  operand_fetch #(.BASE(WGT_BASE)) i_wgt_fetch (
    .clk       (clk),
    .resetn    (resetn),
    .restart   (fetch_restart),
    .word_req  (wgt_req),
    .word_ack  (wgt_ack),
    .word      (wgt_word),
    .mem_req   (wgt_mem_req),
    .mem_addr  (wgt_mem_addr),
    .mem_ack   (wgt_mem_ack),
    .mem_rdata (arb_rdata)
  );

  conv_sequencer i_conv_sequencer (
    .clk           (clk),
    .resetn        (resetn),
    .start         (start),
    .depth         (depth),
    .groups        (groups),
    .busy          (busy),
    .fetch_restart (fetch_restart),
    .pix_req       (pix_req),
    .pix_ack       (pix_ack),
    .pix_word      (pix_word),
    .wgt_req       (wgt_req),
    .wgt_ack       (wgt_ack),
    .wgt_word      (wgt_word),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .s_pixels      (s_pixels),
    .s_weights     (s_weights),
    .s_last        (s_last),
    .out_last_done (out_last_done)
  );

  proc_engine i_proc_engine (
    .clk       (clk),
    .resetn    (engine_resetn),
    .s_valid   (s_valid),
    .s_last    (s_last),
    .s_ready   (s_ready),
    .s_pixels  (s_pixels),
    .s_weights (s_weights),
    .m_ready   (out_ready),
    .m_valid   (out_valid),
    .m_last    (out_last),
    .m_data    (out_data)
  );

endmodule

`default_nettype wire

// File: tests/result_checker.sv
`timescale 1ns/1ps
`default_nettype none

module result_checker import cnn_pkg::*; #(
  parameter int WGT_BASE = 128
) (
  input  logic   clk,
  input  logic   resetn,
  // host load bus, mirrored into a private memory image
  input  logic   load_we,
  input  addr_t  load_addr,
  input  word_t  load_data,
  input  logic   start,
  input  count_t depth,
  input  count_t groups,
  input  logic   busy,
  // output stream of the DUT
  input  logic   out_valid,
  input  logic   out_ready,
  input  acc_t   [ROWS-1:0] out_data,
  input  logic   out_last,
  output int     error_count,
  output int     output_count
);

  word_t mem_img [2**ADDR_BITS];
  // expected rows in arrival order, one last flag per column
  acc_t exp_data_q [$];
  logic exp_last_q [$];
  int errors = 0;
  int outputs = 0;
  int run_outputs = 0;
  int run_expected = 0;
  logic busy_q = 1'b0;
  // final column of the run went out on the previous edge
  logic final_seen = 1'b0;

  assign error_count = errors;
  assign output_count = outputs;

  // byte r of a pixel word is row r
  function automatic int pixel_of(input word_t w, input int r);
    pixel_t p;
    p = w[r*X_BITS +: X_BITS];
    return int'(p);
  endfunction

  // byte c of a weight word is column c
  function automatic int weight_of(input word_t w, input int c);
    weight_t k;
    k = w[c*K_BITS +: K_BITS];
    return int'(k);
  endfunction

  // column c sees the pixel word from c beats back, zeros before beat 0
  task automatic build_expected(input int d, input int n);
    int sum;
    exp_data_q.delete();
    exp_last_q.delete();
    run_outputs = 0;
    run_expected = n * COLS;
    for (int g = 0; g < n; g++) begin
      // top column leaves first
      for (int c = COLS - 1; c >= 0; c--) begin
        for (int r = 0; r < ROWS; r++) begin
          sum = 0;
          for (int t = g * d; t < (g + 1) * d; t++) begin
            if (t >= c) begin
              sum += pixel_of(mem_img[addr_t'(t - c)], r)
                * weight_of(mem_img[addr_t'(WGT_BASE + t)], c);
            end
          end
          exp_data_q.push_back(acc_t'(sum));
        end
        exp_last_q.push_back(c == 0);
      end
    end
  endtask

  task automatic check_output();
    acc_t want;
    logic want_last;
    int col;
    if (exp_last_q.size() == 0) begin
      $display("unexpected output at %0t, no result was pending", $time);
      errors++;
    end else begin
      col = COLS - 1 - (run_outputs % COLS);
      for (int r = 0; r < ROWS; r++) begin
        want = exp_data_q.pop_front();
        if (out_data[r] !== want) begin
          $display("[FAIL] %0t: group %0d column %0d row %0d got %0d expected %0d",
            $time, run_outputs / COLS, col, r, out_data[r], want);
          errors++;
        end
      end
      want_last = exp_last_q.pop_front();
      if (out_last !== want_last) begin
        $display("[FAIL] %0t: group %0d column %0d last flag %0b expected %0b",
          $time, run_outputs / COLS, col, out_last, want_last);
        errors++;
      end
      final_seen = (exp_last_q.size() == 0);
    end
    outputs++;
    run_outputs++;
  endtask

  // sampled on the rising edge, inputs move 1 ns later
  always @(posedge clk) begin
    if (!resetn) begin
      busy_q = 1'b0;
      final_seen = 1'b0;
    end else begin
      if (load_we) begin
        mem_img[load_addr] = load_data;
      end
      if (start && !busy) begin
        build_expected(int'(depth), int'(groups));
      end
      // busy has to drop the cycle after the final m_last
      if (final_seen && busy) begin
        $display("busy still high one cycle after the final output at %0t", $time);
        errors++;
      end
      final_seen = 1'b0;
      if (out_valid && out_ready) begin
        check_output();
      end
      if (busy_q && !busy && run_outputs != run_expected) begin
        $display("busy fell at %0t after %0d of %0d outputs",
          $time, run_outputs, run_expected);
        errors++;
      end
      busy_q = busy;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_cnn_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_engine import cnn_pkg::*; ();

  localparam int WGT_BASE = 128;
  localparam int N_ROWS = 5;

  // stimulus table, one run per entry
  int depth_tab [N_ROWS] = '{1, 8, 8, 4, 3};
  int groups_tab [N_ROWS] = '{1, 3, 3, 2, 5};
  // 1 takes out_ready from a random bit
  bit ready_mode_tab [N_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0};

  logic clk = 1'b0;
  logic resetn = 1'b0;
  logic load_we = 1'b0;
  addr_t load_addr = '0;
  word_t load_data = '0;
  logic start = 1'b0;
  count_t depth = '0;
  count_t groups = '0;
  logic busy;
  logic out_valid;
  logic out_ready = 1'b0;
  acc_t [ROWS-1:0] out_data;
  logic out_last;

  int checker_errors;
  int checker_outputs;
  int cycles = 0;
  int cycle_limit = 0;
  logic rand_ready = 1'b0;
  logic [31:0] data_rng = 32'h941c920c;
  logic [31:0] ready_rng = 32'h941c920c;

  always #50 clk = ~clk;

  cnn_engine #(.WGT_BASE(addr_t'(WGT_BASE))) i_cnn_engine (
    .clk       (clk),
    .resetn    (resetn),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (load_data),
    .start     (start),
    .depth     (depth),
    .groups    (groups),
    .busy      (busy),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last)
  );

  result_checker #(.WGT_BASE(WGT_BASE)) result_checker (
    .clk          (clk),
    .resetn       (resetn),
    .load_we      (load_we),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .start        (start),
    .depth        (depth),
    .groups       (groups),
    .busy         (busy),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_last     (out_last),
    .error_count  (checker_errors),
    .output_count (checker_outputs)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 60 cycles per beat over the whole table plus slack for reset and drain
  function automatic int run_budget();
    int total;
    total = 500;
    for (int i = 0; i < N_ROWS; i++) begin
      total += 60 * depth_tab[i] * groups_tab[i];
    end
    return total;
  endfunction

  // back-pressure on the output stream
  always @(posedge clk) begin
    #1;
    ready_rng = xorshift32(ready_rng);
    out_ready = rand_ready ? ready_rng[0] : 1'b1;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // fresh pixel and weight words for the beats of one run
  task automatic load_run_data(input int beats);
    for (int i = 0; i < 2 * beats; i++) begin
      @(posedge clk);
      #1;
      load_we = 1'b1;
      // even slots are pixels, odd slots are weights
      load_addr = (i % 2 == 0) ? addr_t'(i / 2) : addr_t'(WGT_BASE + i / 2);
      load_data = data_rng;
      data_rng = xorshift32(data_rng);
    end
    @(posedge clk);
    #1;
    load_we = 1'b0;
  endtask

  task automatic start_run(input int d, input int n);
    @(posedge clk);
    #1;
    start = 1'b1;
    depth = count_t'(d);
    groups = count_t'(n);
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  // leave two edges so the checker sees busy fall
  task automatic wait_idle();
    @(posedge clk);
    while (busy) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  initial begin
    int errs_before;
    int outs_before;
    cycle_limit = run_budget();
    repeat (8) @(posedge clk);
    #1;
    resetn = 1'b1;
    for (int i = 0; i < N_ROWS; i++) begin
      errs_before = checker_errors;
      outs_before = checker_outputs;
      @(negedge clk);
      rand_ready = ready_mode_tab[i];
      load_run_data(depth_tab[i] * groups_tab[i]);
      start_run(depth_tab[i], groups_tab[i]);
      wait_idle();
      $display("row %0d: depth %0d, groups %0d, random ready %0b, outputs %0d, errors %0d",
        i, depth_tab[i], groups_tab[i], ready_mode_tab[i],
        checker_outputs - outs_before, checker_errors - errs_before);
    end
    $display("rows %0d, outputs %0d, errors %0d", N_ROWS, checker_outputs, checker_errors);
    if (checker_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cnn_engine.f
rtl/cnn_pkg.sv
rtl/operand_mem.sv
rtl/mem_arbiter.sv
rtl/operand_fetch.sv
rtl/conv_sequencer.sv
rtl/proc_engine.sv
rtl/cnn_engine.sv
tests/result_checker.sv
tests/tb_cnn_engine.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert --timescale 1ns/1ps
TOP       ?= tb_cnn_engine
FILELIST  ?= cnn_engine.f
PASS_MSG  := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
